//--- src/ppu_pkg.sv
//----------------------------------------------------------
// PPU shared definitions
// Data widths, CPU register map and frame timing constants
//----------------------------------------------------------
package ppu_pkg;

  typedef logic [7:0]  byte_t;      // CPU data byte
  typedef logic [2:0]  reg_addr_t;  // CPU register select
  typedef logic [8:0]  scan_t;      // Cycle or scanline count

  // Scroll counter {fine Y[14:12], name table[11:10], coarse Y[9:5], coarse X[4:0]}
  typedef logic [14:0] loopy_t;

  typedef logic [13:0] vram_addr_t; // VRAM address
  typedef logic [4:0]  pal_idx_t;   // Palette index
  typedef logic [5:0]  color_t;     // Output colour
  typedef logic [3:0]  bg_pix_t;    // {attribute[1:0], pattern[1:0]}

  // CPU register map
  localparam reg_addr_t REG_CTRL   = 3'd0;
  localparam reg_addr_t REG_MASK   = 3'd1;
  localparam reg_addr_t REG_STATUS = 3'd2;
  localparam reg_addr_t REG_SCROLL = 3'd5;
  localparam reg_addr_t REG_ADDR   = 3'd6;
  localparam reg_addr_t REG_DATA   = 3'd7;

  // Line timing, 341 cycles per line
  localparam logic [5:0] LAST_CYCLE_GROUP = 6'd42;  // Cycles 336..343
  localparam logic [3:0] LINE_END_LOW     = 4'd4;   // Cycle 340 inside that group

  // Frame timing, 262 lines per frame
  localparam scan_t VBLANK_START_LINE = 9'd240;  // Also the idle line after the picture
  localparam scan_t VBLANK_END_LINE   = 9'd260;
  localparam scan_t PRE_RENDER_LINE   = 9'd511;  // Line -1

  // VRAM address decode
  localparam logic [5:0] PAL_PAGE = 6'h3F;  // Palette lives at 3F00..3FFF
  localparam logic [3:0] ATTR_ROW = 4'hF;   // Attribute table at xx3C0 of each name table

endpackage

//--- src/ppu_ifs.sv
//----------------------------------------------------------
// PPU internal buses
// Frame timing broadcast and control register view
//----------------------------------------------------------
`timescale 1ns/1ps

interface ppu_scan_if;
  ppu_pkg::scan_t scanline;
  ppu_pkg::scan_t cycle;
  logic is_rendering;         // Playfield on, outside vblank and line 240
  logic is_pre_render;        // Line -1
  logic at_last_cycle_group;
  logic end_of_line;          // Cycle 340
  logic entering_vblank;
  logic exiting_vblank;
  logic in_vblank;

  modport timing (output scanline, cycle, is_rendering, is_pre_render, at_last_cycle_group,
                  end_of_line, entering_vblank, exiting_vblank, in_vblank);
  modport sink (input scanline, cycle, is_rendering, is_pre_render, at_last_cycle_group,
                end_of_line, entering_vblank, exiting_vblank, in_vblank);
endinterface

interface ppu_ctrl_if;
  logic bg_patt;              // Background pattern table select
  logic grayscale;
  logic playfield_clip;       // Show background in the left 8 pixels
  logic enable_playfield;
  ppu_pkg::loopy_t loopy;     // Current VRAM address
  logic [2:0] fine_x;
  logic is_pal_address;

  modport regs (output bg_patt, grayscale, playfield_clip, enable_playfield, loopy, fine_x,
                is_pal_address);
  modport view (input bg_patt, grayscale, playfield_clip, enable_playfield, loopy, fine_x,
                is_pal_address);
endinterface

//--- src/ppu_timing.sv
//----------------------------------------------------------
// PPU frame timing
// Cycle and scanline counters, vblank flag, render window
//----------------------------------------------------------
`timescale 1ns/1ps

module ppu_timing (
  input  logic       clk,
  input  logic       reset,
  ppu_scan_if.timing scan,
  ppu_ctrl_if.view   ctrl
);

  // Cycle 340, the last one of a line
  localparam ppu_pkg::scan_t LAST_CYCLE =
    {ppu_pkg::LAST_CYCLE_GROUP, 3'b000} + ppu_pkg::LINE_END_LOW;

  ppu_pkg::scan_t cycle_q;
  ppu_pkg::scan_t line_q;
  logic           in_vblank_q;
  logic           last_group;
  logic           line_end;
  logic           vbl_enter;
  logic           vbl_exit;

  assign last_group = cycle_q[8:3] == ppu_pkg::LAST_CYCLE_GROUP;
  assign line_end   = last_group && cycle_q[3:0] == ppu_pkg::LINE_END_LOW;
  assign vbl_enter  = line_end && line_q == ppu_pkg::VBLANK_START_LINE;  // End of line 240
  assign vbl_exit   = line_end && line_q == ppu_pkg::VBLANK_END_LINE;    // End of line 260

  always_ff @(posedge clk) begin
    if (reset) begin
      cycle_q     <= '0;
      line_q      <= '0;
      in_vblank_q <= 1'b1;
    end else begin
      cycle_q <= line_end ? '0 : cycle_q + 9'd1;
      // After 260 comes -1, and -1 rolls over to 0
      if (line_end) begin
        line_q <= vbl_exit ? ppu_pkg::PRE_RENDER_LINE : line_q + 9'd1;
      end
      if (vbl_enter) begin
        in_vblank_q <= 1'b1;
      end else if (vbl_exit) begin
        in_vblank_q <= 1'b0;
      end
    end
  end

  assign scan.cycle               = cycle_q;
  assign scan.scanline            = line_q;
  assign scan.in_vblank           = in_vblank_q;
  assign scan.at_last_cycle_group = last_group;
  assign scan.end_of_line         = line_end;
  assign scan.entering_vblank     = vbl_enter;
  assign scan.exiting_vblank      = vbl_exit;
  assign scan.is_pre_render       = line_q == ppu_pkg::PRE_RENDER_LINE;

  // Line 240 is idle even though vblank has not started yet
  assign scan.is_rendering = ctrl.enable_playfield && !in_vblank_q &&
                             line_q != ppu_pkg::VBLANK_START_LINE;

  a_cycle_range: assert property (@(posedge clk) disable iff (reset)
    cycle_q <= LAST_CYCLE);

endmodule

//--- src/ppu_regs.sv
//----------------------------------------------------------
// PPU CPU register file
// Control/mask/status, scroll and address counters, VRAM port
//----------------------------------------------------------
`timescale 1ns/1ps

module ppu_regs (
  input  logic                clk,
  input  logic                reset,
  input  ppu_pkg::reg_addr_t  ain,
  input  ppu_pkg::byte_t      din,
  input  logic                read,
  input  logic                write,
  ppu_scan_if.sink            scan,
  input  ppu_pkg::vram_addr_t render_addr,
  input  ppu_pkg::color_t     color,
  input  ppu_pkg::byte_t      vram_din,
  ppu_ctrl_if.regs            ctrl,
  output ppu_pkg::byte_t      dout,
  output logic                nmi,
  output logic                vram_r,
  output logic                vram_w,
  output ppu_pkg::vram_addr_t vram_a,
  output ppu_pkg::byte_t      vram_dout,
  output logic                pal_write
);

  ppu_pkg::loopy_t loopy_v;    // Current VRAM address
  ppu_pkg::loopy_t loopy_tmp;  // Temporary address, copied into loopy_v
  logic [2:0]      fine_x;
  logic            addr_latch; // Second write of a scroll/address pair
  logic            incr_32;    // Data access steps by a row
  logic            vbl_enable;
  logic            bg_patt;
  logic            grayscale;
  logic            playfield_clip;
  logic            enable_playfield;
  logic            vblank_flag;
  logic            rd_pending; // VRAM read issued last cycle
  ppu_pkg::byte_t  read_buf;
  ppu_pkg::scan_t  cyc;
  logic            rendering;
  logic            pal_addr;
  logic            data_access;
  logic            status_read;

  assign cyc         = scan.cycle;
  assign rendering   = scan.is_rendering;
  assign pal_addr    = loopy_v[13:8] == ppu_pkg::PAL_PAGE;
  assign data_access = (read || write) && ain == ppu_pkg::REG_DATA;
  assign status_read = read && ain == ppu_pkg::REG_STATUS;

  always_ff @(posedge clk) begin
    if (reset) begin
      loopy_v          <= '0;
      loopy_tmp        <= '0;
      fine_x           <= '0;
      addr_latch       <= 1'b0;
      incr_32          <= 1'b0;
      vbl_enable       <= 1'b0;
      bg_patt          <= 1'b0;
      grayscale        <= 1'b0;
      playfield_clip   <= 1'b0;
      enable_playfield <= 1'b0;
    end else begin
      if (rendering) begin
        // Coarse X steps right after each attribute fetch
        if (cyc[2:0] == 3'd3 && (cyc < 9'd256 || (cyc >= 9'd320 && cyc < 9'd336))) begin
          loopy_v[4:0] <= loopy_v[4:0] + 5'd1;
          loopy_v[10]  <= loopy_v[10] ^ (loopy_v[4:0] == 5'd31);  // Next name table
        end
        if (cyc == 9'd251) begin  // Fine Y, carry into coarse Y
          loopy_v[14:12] <= loopy_v[14:12] + 3'd1;
          if (loopy_v[14:12] == 3'd7) begin
            if (loopy_v[9:5] == 5'd29) begin  // Row 29 is the last tile row
              loopy_v[9:5] <= '0;
              loopy_v[11]  <= ~loopy_v[11];
            end else begin
              loopy_v[9:5] <= loopy_v[9:5] + 5'd1;
            end
          end
        end
        if (cyc == 9'd256)  // Horizontal copy
          {loopy_v[10], loopy_v[4:0]} <= {loopy_tmp[10], loopy_tmp[4:0]};
        if (cyc == 9'd304 && scan.is_pre_render)  // Full copy before the frame
          loopy_v <= loopy_tmp;
      end

      if (write && ain == ppu_pkg::REG_CTRL) begin
        loopy_tmp[11:10] <= din[1:0];
        incr_32          <= din[2];
        bg_patt          <= din[4];
        vbl_enable       <= din[7];
      end else if (write && ain == ppu_pkg::REG_MASK) begin
        grayscale        <= din[0];
        playfield_clip   <= din[1];
        enable_playfield <= din[3];
      end else if (write && ain == ppu_pkg::REG_SCROLL) begin
        if (!addr_latch) begin
          loopy_tmp[4:0] <= din[7:3];  // X
          fine_x         <= din[2:0];
        end else begin
          loopy_tmp[9:5]   <= din[7:3];  // Y
          loopy_tmp[14:12] <= din[2:0];
        end
        addr_latch <= ~addr_latch;
      end else if (write && ain == ppu_pkg::REG_ADDR) begin
        if (!addr_latch) begin
          loopy_tmp[13:8] <= din[5:0];  // High byte first
          loopy_tmp[14]   <= 1'b0;
        end else begin
          loopy_tmp[7:0] <= din;
          loopy_v        <= {loopy_tmp[14:8], din};
        end
        addr_latch <= ~addr_latch;
      end else if (status_read) begin
        addr_latch <= 1'b0;
      end else if (data_access && !rendering) begin
        loopy_v <= loopy_v + (incr_32 ? 15'd32 : 15'd1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      vblank_flag <= 1'b0;
      rd_pending  <= 1'b0;
    end else begin
      if (status_read || scan.exiting_vblank)
        vblank_flag <= 1'b0;
      else if (scan.entering_vblank)
        vblank_flag <= 1'b1;
      rd_pending <= vram_r;
    end
  end

  // VRAM answers one clock after the address
  always_ff @(posedge clk) begin
    if (rd_pending)
      read_buf <= vram_din;
  end

  // CPU reads and background fetches on even cycles
  assign vram_r    = (read && ain == ppu_pkg::REG_DATA) ||
                     (rendering && !cyc[0] && !scan.end_of_line);
  assign vram_w    = write && ain == ppu_pkg::REG_DATA && !pal_addr && !rendering;
  assign pal_write = write && ain == ppu_pkg::REG_DATA && pal_addr && !rendering;
  assign vram_a    = rendering ? render_addr : loopy_v[13:0];
  assign vram_dout = din;
  assign nmi       = vblank_flag && vbl_enable;

  always_comb begin
    if (ain == ppu_pkg::REG_STATUS)
      dout = {vblank_flag, 2'b00, 5'b00000};  // No sprite flags
    else if (pal_addr)
      dout = {2'b00, color};                  // Palette reads bypass the buffer
    else
      dout = read_buf;
  end

  assign ctrl.bg_patt          = bg_patt;
  assign ctrl.grayscale        = grayscale;
  assign ctrl.playfield_clip   = playfield_clip;
  assign ctrl.enable_playfield = enable_playfield;
  assign ctrl.loopy            = loopy_v;
  assign ctrl.fine_x           = fine_x;
  assign ctrl.is_pal_address   = pal_addr;

  a_vram_rw_excl: assert property (@(posedge clk) disable iff (reset)
    !(vram_w && vram_r));

endmodule

//--- src/bg_renderer.sv
//----------------------------------------------------------
// Background renderer
// Tile fetch addressing and pixel shift pipeline
//----------------------------------------------------------
`timescale 1ns/1ps

module bg_renderer (
  input  logic                clk,
  input  logic                reset,
  ppu_scan_if.sink            scan,
  ppu_ctrl_if.view            ctrl,
  input  ppu_pkg::byte_t      vram_din,
  output ppu_pkg::vram_addr_t render_addr,
  output ppu_pkg::bg_pix_t    bg_pixel
);

  logic [15:0]     patt_lo_pipe;  // Pattern plane 0, two tiles
  logic [15:0]     patt_hi_pipe;  // Pattern plane 1
  logic [8:0]      attr_lo_pipe;
  logic [8:0]      attr_hi_pipe;
  ppu_pkg::byte_t  tile;          // Name table byte
  logic [1:0]      attr_bits;     // Quadrant of the attribute byte
  ppu_pkg::byte_t  plane0;
  logic [2:0]      phase;         // Position in the 8-cycle fetch
  ppu_pkg::loopy_t v;

  // Leftmost pixel goes to bit 0
  function automatic ppu_pkg::byte_t bit_rev(input ppu_pkg::byte_t b);
    ppu_pkg::byte_t r;
    for (int i = 0; i < 8; i++) begin
      r[i] = b[7 - i];
    end
    return r;
  endfunction

  assign phase = scan.cycle[2:0];
  assign v     = ctrl.loopy;

  always_comb begin
    case (phase[2:1])
      2'd0:    render_addr = {2'b10, v[11:0]};  // Name table
      2'd1:    render_addr = {2'b10, v[11:10], ppu_pkg::ATTR_ROW, v[9:7], v[4:2]};
      default: render_addr = {1'b0, ctrl.bg_patt, tile, phase[1], v[14:12]};  // Planes 0/1
    endcase
  end

  always_ff @(posedge clk) begin
    case (phase)
      3'd1: tile      <= vram_din;
      3'd3: attr_bits <= vram_din[{v[6], v[1], 1'b0} +: 2];  // Coarse Y bit 1, coarse X bit 1
      3'd5: plane0    <= vram_din;
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      patt_lo_pipe <= '0;
      patt_hi_pipe <= '0;
      attr_lo_pipe <= '0;
      attr_hi_pipe <= '0;
    end else if (!scan.at_last_cycle_group) begin
      patt_lo_pipe[14:0] <= patt_lo_pipe[15:1];
      patt_hi_pipe[14:0] <= patt_hi_pipe[15:1];
      attr_lo_pipe[7:0]  <= attr_lo_pipe[8:1];
      attr_hi_pipe[7:0]  <= attr_hi_pipe[8:1];
      if (phase == 3'd7) begin  // Plane 1 arrives now, load the next tile
        patt_lo_pipe[15:8] <= bit_rev(plane0);
        patt_hi_pipe[15:8] <= bit_rev(vram_din);
        attr_lo_pipe[8]    <= attr_bits[0];
        attr_hi_pipe[8]    <= attr_bits[1];
      end
    end
  end

  // Fine X picks the tap
  assign bg_pixel = {attr_hi_pipe[ctrl.fine_x], attr_lo_pipe[ctrl.fine_x],
                     patt_hi_pipe[ctrl.fine_x], patt_lo_pipe[ctrl.fine_x]};

endmodule

//--- src/palette_out.sv
//----------------------------------------------------------
// Palette and colour output
// Left-edge clip, 32-entry palette RAM and grayscale
//----------------------------------------------------------
`timescale 1ns/1ps

module palette_out (
  input  logic             clk,
  ppu_scan_if.sink         scan,
  ppu_ctrl_if.view         ctrl,
  input  ppu_pkg::bg_pix_t bg_pixel,
  input  ppu_pkg::byte_t   din,
  input  logic             pal_write,
  output ppu_pkg::color_t  color
);

  ppu_pkg::color_t   pal_mem [0:31];
  logic              show_bg;
  ppu_pkg::bg_pix_t  pixel;
  ppu_pkg::pal_idx_t rd_idx;
  ppu_pkg::pal_idx_t eff_idx;
  logic              mirror_hole;
  ppu_pkg::color_t   raw;

  // Hide pattern bits in cycles 0..7 unless clipping is off
  assign show_bg = (ctrl.playfield_clip || scan.cycle[7:3] != 5'd0) && ctrl.enable_playfield;
  assign pixel   = {bg_pixel[3:2], show_bg ? bg_pixel[1:0] : 2'b00};

  always_comb begin
    if (scan.is_rendering)
      rd_idx = {1'b0, pixel};
    else if (ctrl.is_pal_address)
      rd_idx = ctrl.loopy[4:0];  // CPU side palette access
    else
      rd_idx = '0;
  end

  // Transparent entries all show the backdrop
  assign eff_idx     = (rd_idx[1:0] == 2'b00) ? '0 : rd_idx;
  assign mirror_hole = rd_idx[3:2] != 2'b00 && rd_idx[1:0] == 2'b00;  // 4, 8, 12 and twins

  always_ff @(posedge clk) begin
    if (pal_write && !mirror_hole)
      pal_mem[eff_idx] <= din[5:0];
  end

  assign raw   = pal_mem[eff_idx];
  assign color = ctrl.grayscale ? {raw[5:4], 4'b0000} : raw;  // Keep luma only

endmodule

//--- src/ppu_top.sv
//----------------------------------------------------------
// PPU top level
// Background-only picture unit, one pixel per clock
//----------------------------------------------------------
`timescale 1ns/1ps

module ppu_top (
  input  logic                clk,
  input  logic                reset,
  input  ppu_pkg::reg_addr_t  ain,
  input  ppu_pkg::byte_t      din,
  input  logic                read,
  input  logic                write,
  input  ppu_pkg::byte_t      vram_din,
  output ppu_pkg::byte_t      dout,
  output logic                nmi,
  output logic                vram_r,
  output logic                vram_w,
  output ppu_pkg::vram_addr_t vram_a,
  output ppu_pkg::byte_t      vram_dout,
  output ppu_pkg::color_t     color,
  output ppu_pkg::scan_t      scanline,
  output ppu_pkg::scan_t      cycle
);

  ppu_scan_if scan_bus ();
  ppu_ctrl_if ctrl_bus ();

  ppu_pkg::vram_addr_t render_addr;
  ppu_pkg::bg_pix_t    bg_pixel;
  logic                pal_write;

  ppu_timing u_timing (
    .clk   (clk),
    .reset (reset),
    .scan  (scan_bus.timing),
    .ctrl  (ctrl_bus.view)
  );

  ppu_regs u_regs (
    .clk         (clk),
    .reset       (reset),
    .ain         (ain),
    .din         (din),
    .read        (read),
    .write       (write),
    .scan        (scan_bus.sink),
    .render_addr (render_addr),
    .color       (color),
    .vram_din    (vram_din),
    .ctrl        (ctrl_bus.regs),
    .dout        (dout),
    .nmi         (nmi),
    .vram_r      (vram_r),
    .vram_w      (vram_w),
    .vram_a      (vram_a),
    .vram_dout   (vram_dout),
    .pal_write   (pal_write)
  );

  bg_renderer u_bg (
    .clk         (clk),
    .reset       (reset),
    .scan        (scan_bus.sink),
    .ctrl        (ctrl_bus.view),
    .vram_din    (vram_din),
    .render_addr (render_addr),
    .bg_pixel    (bg_pixel)
  );

  palette_out u_pal (
    .clk       (clk),
    .scan      (scan_bus.sink),
    .ctrl      (ctrl_bus.view),
    .bg_pixel  (bg_pixel),
    .din       (din),
    .pal_write (pal_write),
    .color     (color)
  );

  assign scanline = scan_bus.scanline;
  assign cycle    = scan_bus.cycle;

endmodule

//--- testbench/ppu_tb_util.svh
//----------------------------------------------------------
// PPU testbench helpers
// LFSR, VRAM data rule, palette reference and value check
//----------------------------------------------------------
`ifndef PPU_TB_UTIL_SVH
`define PPU_TB_UTIL_SVH

logic [15:0] lfsr_state = 16'd23313;  // Galois LFSR seed
logic [5:0]  pal_shadow [0:31];       // Expected palette contents

// One Galois step, taps for x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsr_step(input logic [15:0] s);
  return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
endfunction

// Eight bits, one LFSR step per bit
function automatic logic [7:0] lfsr_byte();
  logic [7:0] b;
  b = '0;
  for (int i = 0; i < 8; i++) begin
    b          = {b[6:0], lfsr_state[0]};
    lfsr_state = lfsr_step(lfsr_state);
  end
  return b;
endfunction

// VRAM contents as a function of the address
function automatic logic [7:0] vram_rule(input logic [13:0] a);
  if (!a[13])
    return 8'hFF;                     // Pattern tables, every pixel set
  else if (a[9:6] == 4'hF)
    return 8'h00;                     // Attribute rows, palette group 0
  else
    return a[7:0];
endfunction

// Entries 4, 8, 12 and their upper twins take no writes
task automatic pal_model_write(input logic [4:0] idx, input logic [7:0] val);
  if (idx[1:0] == 2'b00 && idx[3:2] != 2'b00) begin
    // Mirror hole, value is dropped
  end else begin
    pal_shadow[(idx[1:0] == 2'b00) ? 5'd0 : idx] = val[5:0];  // 16 lands on 0
  end
endtask

// Expected colour for a palette index
function automatic logic [5:0] expected_color(input logic [4:0] idx, input logic gray);
  logic [5:0] c;
  c = pal_shadow[(idx[1:0] == 2'b00) ? 5'd0 : idx];  // Backdrop for every xx00
  return gray ? {c[5:4], 4'b0000} : c;
endfunction

task automatic check_eq(input string name, input logic [31:0] expected,
                        input logic [31:0] actual);
  if (actual !== expected) begin
    $display("Mismatch in %s: expected %0h, actual %0h", name, expected, actual);
    $display("=== FAIL ===");
    $fatal(1, "Stopped at first error");
  end
endtask

`endif

//--- testbench/ppu_tb.sv
//----------------------------------------------------------
// PPU testbench
// Frame timing, vblank, CPU VRAM access, palette, background
//----------------------------------------------------------
`timescale 1ns/1ps

module ppu_tb;

  localparam int LINE_CYCLES    = 341;
  localparam int FRAME_LINES    = 262;
  localparam int FRAME_CYCLES   = LINE_CYCLES * FRAME_LINES;
  localparam int SETUP_CYCLES   = 1024;  // Reset plus all register accesses
  localparam int TIMEOUT_CYCLES = 3 * FRAME_CYCLES + SETUP_CYCLES;

  logic                clk;
  logic                reset;
  ppu_pkg::reg_addr_t  ain;
  ppu_pkg::byte_t      din;
  logic                read;
  logic                write;
  ppu_pkg::byte_t      vram_din;
  ppu_pkg::byte_t      dout;
  logic                nmi;
  logic                vram_r;
  logic                vram_w;
  ppu_pkg::vram_addr_t vram_a;
  ppu_pkg::byte_t      vram_dout;
  ppu_pkg::color_t     color;
  ppu_pkg::scan_t      scanline;
  ppu_pkg::scan_t      cycle;

  ppu_pkg::scan_t exp_cycle;      // Counter model
  ppu_pkg::scan_t exp_line;
  ppu_pkg::scan_t prev_line = '0;
  logic           counting = 1'b0;
  int             frame_cycles = 0;
  int             frame_lines = 0;
  int             frames_done = 0;
  int             ticks = 0;

  `include "ppu_tb_util.svh"

  ppu_top u_dut (
    .clk       (clk),
    .reset     (reset),
    .ain       (ain),
    .din       (din),
    .read      (read),
    .write     (write),
    .vram_din  (vram_din),
    .dout      (dout),
    .nmi       (nmi),
    .vram_r    (vram_r),
    .vram_w    (vram_w),
    .vram_a    (vram_a),
    .vram_dout (vram_dout),
    .color     (color),
    .scanline  (scanline),
    .cycle     (cycle)
  );

  always #4 clk = ~clk;

  // VRAM answers one clock after the address
  always @(posedge clk) vram_din <= vram_rule(vram_a);

  // Next {line, cycle}, line 260 is followed by -1 (511)
  function automatic logic [17:0] next_position(input logic [8:0] line, input logic [8:0] cyc);
    if (cyc != 9'd340)
      return {line, cyc + 9'd1};
    else if (line == 9'd260)
      return {9'd511, 9'd0};
    else if (line == 9'd511)
      return {9'd0, 9'd0};
    else
      return {line + 9'd1, 9'd0};
  endfunction

  always @(posedge clk) begin
    if (reset) begin
      exp_cycle <= '0;
      exp_line  <= '0;
    end else begin
      {exp_line, exp_cycle} <= next_position(exp_line, exp_cycle);
    end
  end

  always @(negedge clk) begin
    if (!reset) begin
      check_eq("cycle_count", exp_cycle, cycle);
      check_eq("scanline_count", exp_line, scanline);
    end
  end

  // Frame length, measured between two -1 to 0 line changes
  always @(negedge clk) begin
    if (scanline == 9'd0 && prev_line == 9'd511) begin
      if (counting) begin
        check_eq("frame_cycles", FRAME_CYCLES, frame_cycles);
        check_eq("frame_lines", FRAME_LINES, frame_lines);
        frames_done++;
      end
      counting     = 1'b1;
      frame_cycles = 0;
      frame_lines  = 0;
    end
    frame_cycles++;
    if (cycle == 9'd0)
      frame_lines++;  // One line start per line
    prev_line = scanline;
  end

  always @(posedge clk) begin
    ticks++;
    if (ticks >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("=== FAIL ===");
      $fatal(1, "Timeout");
    end
  end

  task automatic cpu_write(input ppu_pkg::reg_addr_t a, input ppu_pkg::byte_t d);
    @(negedge clk);
    ain   = a;
    din   = d;
    write = 1'b1;
    @(negedge clk);
    write = 1'b0;
  endtask

  // dout is combinational inside the strobe cycle
  task automatic cpu_read(input ppu_pkg::reg_addr_t a, output ppu_pkg::byte_t d);
    @(negedge clk);
    ain  = a;
    read = 1'b1;
    #2 d = dout;
    @(negedge clk);
    read = 1'b0;
  endtask

  task automatic vram_write_check(input logic [13:0] exp_addr, input ppu_pkg::byte_t d);
    @(negedge clk);
    ain   = ppu_pkg::REG_DATA;
    din   = d;
    write = 1'b1;
    #2;
    check_eq("vram_w_pulse", 1'b1, vram_w);
    check_eq("vram_r_on_write", 1'b0, vram_r);
    check_eq("vram_a_write", exp_addr, vram_a);
    check_eq("vram_dout", d, vram_dout);
    @(negedge clk);
    write = 1'b0;
    #2 check_eq("vram_w_end", 1'b0, vram_w);
    @(negedge clk);
  endtask

  // Data read strobe, the VRAM read goes out in the same cycle
  task automatic vram_read_check(input logic [13:0] exp_addr, output ppu_pkg::byte_t d);
    @(negedge clk);
    ain  = ppu_pkg::REG_DATA;
    read = 1'b1;
    #2;
    d = dout;
    check_eq("vram_r_pulse", 1'b1, vram_r);
    check_eq("vram_w_on_read", 1'b0, vram_w);
    check_eq("vram_a_read", exp_addr, vram_a);
    @(negedge clk);
    read = 1'b0;
    #2 check_eq("vram_r_end", 1'b0, vram_r);
  endtask

  task automatic set_address(input logic [13:0] a);
    cpu_write(ppu_pkg::REG_ADDR, {2'b00, a[13:8]});  // High byte first
    cpu_write(ppu_pkg::REG_ADDR, a[7:0]);
  endtask

  task automatic wait_pos(input int line, input int cyc);
    while (!(scanline == line && cycle == cyc))
      @(negedge clk);
  endtask

  task automatic palette_readback(input logic gray);
    ppu_pkg::byte_t rd;
    set_address(14'h3F00);
    for (int i = 0; i < 32; i++) begin
      cpu_read(ppu_pkg::REG_DATA, rd);
      check_eq(gray ? "palette_gray" : "palette_read", {2'b00, expected_color(i, gray)}, rd);
    end
  endtask

  // Clip off shows the backdrop at cycles 2..5, every tile pixel is index 3
  task automatic check_background(input int first, input int last, input logic clip_on);
    int lo;
    lo = clip_on ? 2 : 16;
    wait_pos(first, 0);
    while (scanline != last + 1) begin
      if (cycle >= lo && cycle <= 239)
        check_eq(clip_on ? "bg_clip_on" : "bg_clip_off", expected_color(5'd3, 1'b0), color);
      if (!clip_on && cycle >= 2 && cycle <= 5)
        check_eq("bg_left_edge", expected_color(5'd0, 1'b0), color);
      @(negedge clk);
    end
  endtask

  initial begin
    ppu_pkg::byte_t rd;
    ppu_pkg::byte_t val;
    clk      = 1'b0;
    reset    = 1'b1;
    ain      = '0;
    din      = '0;
    read     = 1'b0;
    write    = 1'b0;
    vram_din = '0;
    repeat (4) @(negedge clk);
    reset = 1'b0;
    check_eq("reset_cycle", 0, cycle);
    check_eq("reset_scanline", 0, scanline);
    check_eq("reset_nmi", 1'b0, nmi);
    check_eq("reset_vram_w", 1'b0, vram_w);

    cpu_write(ppu_pkg::REG_CTRL, 8'h80);  // Interrupt on, step 1
    set_address(14'h2123);
    vram_write_check(14'h2123, 8'hA1);
    vram_write_check(14'h2124, 8'hB2);
    cpu_write(ppu_pkg::REG_CTRL, 8'h84);  // Step 32
    vram_write_check(14'h2125, 8'hC3);
    check_eq("vram_a_after_step32", 14'h2145, vram_a);

    // Prime the read buffer so the stale byte is known
    set_address(14'h2123);
    cpu_read(ppu_pkg::REG_DATA, rd);
    set_address(14'h2045);
    vram_read_check(14'h2045, rd);
    check_eq("vram_read_stale", vram_rule(14'h2123), rd);
    vram_read_check(14'h2065, rd);  // Still stepping by 32
    check_eq("vram_read_2045", vram_rule(14'h2045), rd);

    cpu_write(ppu_pkg::REG_CTRL, 8'h80);
    set_address(14'h3F00);
    for (int i = 0; i < 32; i++) begin
      val = lfsr_byte();
      cpu_write(ppu_pkg::REG_DATA, val);
      pal_model_write(i, val);
    end
    palette_readback(1'b0);
    cpu_write(ppu_pkg::REG_MASK, 8'h01);  // Grayscale only
    palette_readback(1'b1);
    cpu_write(ppu_pkg::REG_MASK, 8'h00);

    // First vblank, then clear it by a status read
    wait_pos(240, 340);
    check_eq("nmi_before_vblank", 1'b0, nmi);
    @(negedge clk);
    check_eq("nmi_vblank_start", 1'b1, nmi);
    wait_pos(250, 0);
    cpu_read(ppu_pkg::REG_STATUS, rd);
    check_eq("status_in_vblank", 8'h80, rd);
    check_eq("nmi_after_status", 1'b0, nmi);
    cpu_read(ppu_pkg::REG_STATUS, rd);
    check_eq("status_second_read", 8'h00, rd);

    // Second vblank runs to its end
    wait_pos(240, 340);
    check_eq("nmi_before_vblank2", 1'b0, nmi);
    @(negedge clk);
    check_eq("nmi_vblank2_start", 1'b1, nmi);
    cpu_write(ppu_pkg::REG_MASK, 8'h08);  // Playfield on, clip off
    wait_pos(260, 340);
    check_eq("nmi_before_end", 1'b1, nmi);
    @(negedge clk);
    check_eq("nmi_vblank_end", 1'b0, nmi);

    check_background(0, 119, 1'b0);
    wait_pos(120, 260);                   // Inside hblank
    cpu_write(ppu_pkg::REG_MASK, 8'h0A);  // Show left 8 pixels
    check_background(121, 239, 1'b1);

    if (frames_done == 1) begin
      $display("=== PASS ===");
      $finish;
    end else begin
      $display("Frame length was never measured over a full frame");
      $display("=== FAIL ===");
      $fatal(1, "Frame count incomplete");
    end
  end

endmodule

//--- src.f
+incdir+testbench
src/ppu_pkg.sv
src/ppu_ifs.sv
src/ppu_timing.sv
src/ppu_regs.sv
src/bg_renderer.sv
src/palette_out.sv
src/ppu_top.sv
testbench/ppu_tb.sv
